/* Bender.yml */
package:
  name: dsi_tx_regs

sources:
  - files:
      - source/dsi_regs_pkg.sv
      - source/dsi_reg_if.sv
      - source/dsi_bus_agent.sv
      - source/dsi_ctrl_regs.sv
      - source/dsi_irq_regs.sv
      - source/dsi_timing_regs.sv
      - source/dsi_tx_regs.sv
  - target: test
    files:
      - sim/tb_clk_gen.sv
      - sim/dsi_tx_regs_tb.sv

/* sim/dsi_tx_regs_input.txt */
# W/R: offset data resp (read data is expected) | P: event 0 underflow 1 lanes 2 clk
# L: lanes_active | Q: idle cycles | I: irq | C: asm lanes clk send num cmd tlpx prep exit go trail
# reset state
R 00 00000300 0
R 04 00000000 0
R 08 00000000 0
R 0C 00080F03 0
R 10 00001E02 0
R 14 00000000 0
C 0 0 0 0 4 000000 08 0F 03 1E 02
I 0
# write and read back
W 00 FFFFFCF7 0
R 00 00000007 0
C 1 1 1 0 1 000000 08 0F 03 1E 02
W 00 00000205 0
W 0C AA123456 0
W 10 FFFF9A7B 0
W 14 CCABCDEF 0
R 0C 00123456 0
R 10 00009A7B 0
R 14 00ABCDEF 0
C 1 0 1 0 3 ABCDEF 12 34 56 9A 7B
W 18 FFFFFFFF 3
R 18 00000000 3
R 02 00000000 3
R 00 00000205 0
R 14 00ABCDEF 0
# send_cmd auto-clear
W 00 0000030F 0
Q 3
C 1 1 1 1 4 ABCDEF 12 34 56 9A 7B
R 00 0000030F 0
L 1
Q 2
C 1 1 1 0 4 ABCDEF 12 34 56 9A 7B
R 00 00000307 0
# flag setting
P 0
P 1
P 2
L 0
Q 2
R 04 0000001F 0
R 08 00000000 0
I 0
# interrupt and write-1-to-clear
W 04 00000000 0
R 04 0000001F 0
W 08 00000004 0
Q 2
I 1
W 04 00000004 0
Q 2
I 0
R 04 0000001B 0
W 08 00000002 0
Q 2
I 1
W 08 00000000 0
Q 2
I 0
W 04 FFFFFFFF 0
R 04 00000000 0

/* sim/dsi_tx_regs_tb.sv */
`timescale 1ns/1ps

module dsi_tx_regs_tb;
    import dsi_regs_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic       clk;
    logic       rst_n;
    logic       irq;
    addr_t      avl_mm_addr;
    logic       avl_mm_read;
    word_t      avl_mm_readdata;
    resp_t      avl_mm_response;
    logic       avl_mm_write;
    word_t      avl_mm_writedata;
    logic       avl_mm_waitrequest;
    logic       packet_assembler_enable;
    logic       lanes_enable;
    logic       clk_out_enable;
    logic       send_cmd;
    lanes_num_t lanes_number;
    cmd_t       cmd_packet;
    timeout_t   tlpx_timeout;
    timeout_t   hs_prepare_timeout;
    timeout_t   hs_exit_timeout;
    timeout_t   hs_go_timeout;
    timeout_t   hs_trail_timeout;
    logic       pix_buffer_underflow_set;
    logic       lanes_ready_set;
    logic       clk_ready_set;
    logic       lanes_active;

    int   mismatches;
    int   timeouts;
    int   other_errs;
    logic abort;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    dsi_tx_regs u_dut (.*);

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            mismatches++;
            $display("ERR %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            mismatches++;
            $display("ERR %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("ERR %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_timeout(input string name, input timeout_t exp, input timeout_t act);
        if (act !== exp) begin
            mismatches++;
            $display("ERR %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_lanes(input string name, input lanes_num_t exp, input lanes_num_t act);
        if (act !== exp) begin
            mismatches++;
            $display("ERR %s expected 0x%h got 0x%h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic verify_field_count(input int got, input int want, input logic [7:0] op);
        if (got != want) begin
            other_errs++;
            abort = 1'b1;
            $display("input line for operation %s has %0d fields instead of %0d", op, got, want);
        end
    endtask

    // data is the write data, or the expected read data for a read.
    task automatic bus_access(input logic is_write, input addr_t ofs, input word_t data,
                              input resp_t exp_resp);
        int cycles;
        cycles = 0;
        @(negedge clk);
        avl_mm_addr      = ofs;
        avl_mm_writedata = is_write ? data : '0;
        avl_mm_write     = is_write;
        avl_mm_read      = !is_write;
        @(negedge clk);
        while (avl_mm_waitrequest && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (avl_mm_waitrequest) begin
            timeouts++;
            abort = 1'b1;
            $display("%s of offset 0x%h was not accepted within %0d cycles",
                     is_write ? "write" : "read", ofs, WAIT_LIMIT);
        end else begin
            check_resp("avl_mm_response", exp_resp, avl_mm_response);
            if (!is_write) begin
                check_word("avl_mm_readdata", data, avl_mm_readdata);
            end
        end
        @(negedge clk);   // request held through the completing edge.
        avl_mm_read  = 1'b0;
        avl_mm_write = 1'b0;
    endtask

    task automatic pulse_event(input int which);
        @(negedge clk);
        pix_buffer_underflow_set = (which == 0);
        lanes_ready_set          = (which == 1);
        clk_ready_set            = (which == 2);
        @(negedge clk);
        pix_buffer_underflow_set = 1'b0;
        lanes_ready_set          = 1'b0;
        clk_ready_set            = 1'b0;
    endtask

    initial begin
        int               fd;
        int               n;
        int               cycles;
        logic [8*16-1:0]  op;
        logic [8*128-1:0] line;
        logic [31:0]      f [11];
        mismatches               = 0;
        timeouts                 = 0;
        other_errs               = 0;
        abort                    = 1'b0;
        avl_mm_addr              = '0;
        avl_mm_read              = 1'b0;
        avl_mm_write             = 1'b0;
        avl_mm_writedata         = '0;
        pix_buffer_underflow_set = 1'b0;
        lanes_ready_set          = 1'b0;
        clk_ready_set            = 1'b0;
        lanes_active             = 1'b0;
        fd                       = 0;
        cycles                   = 0;
        while (rst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            abort = 1'b1;
            $display("reset was not released within %0d cycles", WAIT_LIMIT);
        end else begin
            fd = $fopen("sim/dsi_tx_regs_input.txt", "r");
            if (fd == 0) begin
                other_errs++;
                abort = 1'b1;
                $display("could not open the stimulus file");
            end
        end
        while (!abort && !$feof(fd)) begin
            n = $fscanf(fd, " %s", op);
            if (n == 1) begin
                case (op[7:0])
                    "#": n = $fgets(line, fd);   // comment line.
                    "W", "R": begin
                        n = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                        verify_field_count(n, 3, op[7:0]);
                        bus_access(op[7:0] == "W", f[0][4:0], f[1], f[2][1:0]);
                    end
                    "P": begin
                        n = $fscanf(fd, "%h", f[0]);
                        verify_field_count(n, 1, op[7:0]);
                        pulse_event(f[0]);
                    end
                    "L": begin
                        n = $fscanf(fd, "%h", f[0]);
                        verify_field_count(n, 1, op[7:0]);
                        @(negedge clk);
                        lanes_active = f[0][0];
                    end
                    "Q": begin
                        n = $fscanf(fd, "%h", f[0]);
                        verify_field_count(n, 1, op[7:0]);
                        repeat (f[0]) @(negedge clk);
                    end
                    "I": begin
                        n = $fscanf(fd, "%h", f[0]);
                        verify_field_count(n, 1, op[7:0]);
                        @(negedge clk);
                        check_bit("irq", f[0][0], irq);
                    end
                    "C": begin
                        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                        verify_field_count(n, 11, op[7:0]);
                        @(negedge clk);
                        check_bit("packet_assembler_enable", f[0][0], packet_assembler_enable);
                        check_bit("lanes_enable", f[1][0], lanes_enable);
                        check_bit("clk_out_enable", f[2][0], clk_out_enable);
                        check_bit("send_cmd", f[3][0], send_cmd);
                        check_lanes("lanes_number", f[4][2:0], lanes_number);
                        check_word("cmd_packet", f[5], word_t'(cmd_packet));
                        check_timeout("tlpx_timeout", f[6][7:0], tlpx_timeout);
                        check_timeout("hs_prepare_timeout", f[7][7:0], hs_prepare_timeout);
                        check_timeout("hs_exit_timeout", f[8][7:0], hs_exit_timeout);
                        check_timeout("hs_go_timeout", f[9][7:0], hs_go_timeout);
                        check_timeout("hs_trail_timeout", f[10][7:0], hs_trail_timeout);
                    end
                    default: begin
                        other_errs++;
                        abort = 1'b1;
                        $display("unknown operation %s in the stimulus file", op[7:0]);
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d other", mismatches, timeouts,
                 other_errs);
        if (mismatches + timeouts + other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // released on the falling edge after two rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* source/dsi_bus_agent.sv */
`timescale 1ns/1ps

module dsi_bus_agent (
    input  logic                clk,
    input  logic                rst_n,
    input  dsi_regs_pkg::addr_t avl_addr,
    input  logic                avl_read,
    input  logic                avl_write,
    input  dsi_regs_pkg::word_t avl_writedata,
    output dsi_regs_pkg::word_t avl_readdata,
    output dsi_regs_pkg::resp_t avl_response,
    output logic                avl_waitrequest,
    dsi_reg_if.agent            regs
);
    import dsi_regs_pkg::*;

    reg_sel_t sel;
    logic     hit;
    logic     req;
    logic     ack;
    word_t    img [NUM_REGS];
    word_t    rd_mux;

    assign img[REG_CR]  = regs.cr_word;
    assign img[REG_ISR] = regs.isr_word;
    assign img[REG_IER] = regs.ier_word;
    assign img[REG_TR1] = regs.tr1_word;
    assign img[REG_TR2] = regs.tr2_word;
    assign img[REG_CMD] = regs.cmd_word;

    // address decode against the offset table.
    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (avl_addr == REG_OFS[i]) begin
                sel[i] = 1'b1;
            end
        end
    end

    assign hit = |sel;
    assign req = avl_read | avl_write;

    // zero when nothing is selected.
    always_comb begin
        rd_mux = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            if (sel[i]) begin
                rd_mux = rd_mux | img[i];
            end
        end
    end

    // strobe only in the first cycle of a write.
    assign regs.wr_sel = sel & {NUM_REGS{avl_write & ~ack}};
    assign regs.wdata  = avl_writedata;

    assign avl_waitrequest = req & ~ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req & ~ack;   // drops again after one cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (req && !ack) begin
            avl_readdata <= avl_read ? rd_mux : '0;
            avl_response <= hit ? RESP_OKAY : RESP_DECERR;
        end
    end

    a_wr_sel_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(regs.wr_sel));

    a_no_rd_wr : assert property (@(posedge clk) disable iff (!rst_n)
        !(avl_read && avl_write));

    a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
        avl_waitrequest |=> $stable(avl_addr));

endmodule

/* source/dsi_ctrl_regs.sv */
`timescale 1ns/1ps

module dsi_ctrl_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    dsi_reg_if.bank                  regs,
    input  logic                     lanes_active,
    output logic                     packet_assembler_enable,
    output logic                     lanes_enable,
    output logic                     clk_out_enable,
    output logic                     send_cmd,
    output dsi_regs_pkg::lanes_num_t lanes_number,
    output dsi_regs_pkg::cmd_t       cmd_packet
);
    import dsi_regs_pkg::*;

    logic                     cr_wr;
    logic                     cmd_wr;
    logic [LANES_FIELD_W-1:0] lanes_field;

    assign cr_wr  = regs.wr_sel[REG_CR];
    assign cmd_wr = regs.wr_sel[REG_CMD];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            packet_assembler_enable <= 1'b0;
            lanes_enable            <= 1'b0;
            clk_out_enable          <= 1'b0;
            send_cmd                <= 1'b0;
            lanes_field             <= RST_LANES_FIELD;
            cmd_packet              <= '0;
        end else begin
            if (cr_wr) begin
                packet_assembler_enable <= regs.wdata[CR_ASM_EN_BIT];
                lanes_enable            <= regs.wdata[CR_LANES_EN_BIT];
                clk_out_enable          <= regs.wdata[CR_CLK_EN_BIT];
                send_cmd                <= regs.wdata[CR_SEND_CMD_BIT];
                lanes_field             <= regs.wdata[CR_LANES_LSB +: LANES_FIELD_W];
            end else if (lanes_active) begin
                send_cmd <= 1'b0;   // command taken once the lanes run.
            end
            if (cmd_wr) begin
                cmd_packet <= regs.wdata[CMD_W-1:0];
            end
        end
    end

    assign lanes_number = lanes_num_t'(lanes_field) + 3'd1;   // field holds lanes minus one.

    always_comb begin
        regs.cr_word                                 = '0;
        regs.cr_word[CR_ASM_EN_BIT]                  = packet_assembler_enable;
        regs.cr_word[CR_LANES_EN_BIT]                = lanes_enable;
        regs.cr_word[CR_CLK_EN_BIT]                  = clk_out_enable;
        regs.cr_word[CR_SEND_CMD_BIT]                = send_cmd;
        regs.cr_word[CR_LANES_LSB +: LANES_FIELD_W]  = lanes_field;
    end

    assign regs.cmd_word = word_t'(cmd_packet);

    a_send_cmd_clear : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(send_cmd) |-> $past(lanes_active || cr_wr));

endmodule

/* source/dsi_irq_regs.sv */
`timescale 1ns/1ps

module dsi_irq_regs (
    input  logic    clk,
    input  logic    rst_n,
    dsi_reg_if.bank regs,
    input  logic    pix_buffer_underflow_set,
    input  logic    lanes_ready_set,
    input  logic    clk_ready_set,
    input  logic    lanes_active,
    output logic    irq
);
    import dsi_regs_pkg::*;

    irq_flags_t flags;
    irq_flags_t ier;
    irq_flags_t flags_set;
    irq_flags_t flags_clr;
    logic       lanes_active_d;
    logic       irq_pending;

    // edge detect against the previous cycle's level.
    always_comb begin
        flags_set                   = '0;
        flags_set.pix_underflow     = pix_buffer_underflow_set;
        flags_set.lanes_ready       = lanes_ready_set;
        flags_set.clk_ready         = clk_ready_set;
        flags_set.lanes_active_rise = lanes_active & ~lanes_active_d;
        flags_set.lanes_active_fall = ~lanes_active & lanes_active_d;
    end

    // write one to clear.
    assign flags_clr = regs.wr_sel[REG_ISR] ? irq_flags_t'(regs.wdata[$bits(irq_flags_t)-1:0])
                                            : irq_flags_t'('0);

    assign irq_pending = |(flags & ier);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags          <= '0;
            ier            <= '0;
            lanes_active_d <= 1'b0;
            irq            <= 1'b0;
        end else begin
            flags          <= (flags | flags_set) & ~flags_clr;   // clear beats set.
            lanes_active_d <= lanes_active;
            irq            <= irq_pending;
            if (regs.wr_sel[REG_IER]) begin
                ier <= regs.wdata[$bits(irq_flags_t)-1:0];
            end
        end
    end

    assign regs.isr_word = word_t'(flags);
    assign regs.ier_word = word_t'(ier);

    a_irq_follows : assert property (@(posedge clk) disable iff (!rst_n)
        !irq_pending |=> !irq);

endmodule

/* source/dsi_reg_if.sv */
`timescale 1ns/1ps

interface dsi_reg_if;
    import dsi_regs_pkg::*;

    reg_sel_t wr_sel;     // one-cycle write strobe.
    word_t    wdata;
    word_t    cr_word;
    word_t    isr_word;
    word_t    ier_word;
    word_t    tr1_word;
    word_t    tr2_word;
    word_t    cmd_word;

    modport agent (
        output wr_sel, wdata,
        input  cr_word, isr_word, ier_word, tr1_word, tr2_word, cmd_word
    );

    modport bank (
        input  wr_sel, wdata,
        output cr_word, isr_word, ier_word, tr1_word, tr2_word, cmd_word
    );

endinterface

/* source/dsi_regs_pkg.sv */
package dsi_regs_pkg;

    localparam int WORD_W        = 32;
    localparam int ADDR_W        = 5;
    localparam int TIMEOUT_W     = 8;
    localparam int CMD_W         = 24;
    localparam int LANES_FIELD_W = 2;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [ADDR_W-1:0]    addr_t;   // avalon byte address.
    typedef logic [1:0]           resp_t;
    typedef logic [TIMEOUT_W-1:0] timeout_t;
    typedef logic [2:0]           lanes_num_t;
    typedef logic [CMD_W-1:0]     cmd_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    typedef enum logic [2:0] {
        REG_CR,
        REG_ISR,
        REG_IER,
        REG_TR1,
        REG_TR2,
        REG_CMD
    } reg_idx_e;

    localparam int NUM_REGS = 6;

    typedef logic [NUM_REGS-1:0] reg_sel_t;   // one-hot, indexed by reg_idx_e.

    localparam addr_t OFS_CR  = 5'h00;
    localparam addr_t OFS_ISR = 5'h04;
    localparam addr_t OFS_IER = 5'h08;
    localparam addr_t OFS_TR1 = 5'h0C;
    localparam addr_t OFS_TR2 = 5'h10;
    localparam addr_t OFS_CMD = 5'h14;

    // offset table in reg_idx_e order.
    localparam addr_t REG_OFS [NUM_REGS] = '{OFS_CR, OFS_ISR, OFS_IER, OFS_TR1, OFS_TR2, OFS_CMD};

    // members listed msb first so pix_underflow lands on bit 0.
    typedef struct packed {
        logic lanes_active_fall;
        logic lanes_active_rise;
        logic clk_ready;
        logic lanes_ready;
        logic pix_underflow;
    } irq_flags_t;

    localparam int CR_ASM_EN_BIT   = 0;
    localparam int CR_LANES_EN_BIT = 1;
    localparam int CR_CLK_EN_BIT   = 2;
    localparam int CR_SEND_CMD_BIT = 3;
    localparam int CR_LANES_LSB    = 8;

    localparam int TR1_TLPX_LSB  = 16;
    localparam int TR1_PREP_LSB  = 8;
    localparam int TR1_EXIT_LSB  = 0;
    localparam int TR2_GO_LSB    = 8;
    localparam int TR2_TRAIL_LSB = 0;

    localparam logic [LANES_FIELD_W-1:0] RST_LANES_FIELD = 2'd3;   // four lanes.
    localparam timeout_t RST_TLPX       = 8'd8;
    localparam timeout_t RST_HS_PREPARE = 8'd15;
    localparam timeout_t RST_HS_EXIT    = 8'd3;
    localparam timeout_t RST_HS_GO      = 8'd30;
    localparam timeout_t RST_HS_TRAIL   = 8'd2;

endpackage

/* source/dsi_timing_regs.sv */
`timescale 1ns/1ps

module dsi_timing_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    dsi_reg_if.bank                regs,
    output dsi_regs_pkg::timeout_t tlpx_timeout,
    output dsi_regs_pkg::timeout_t hs_prepare_timeout,
    output dsi_regs_pkg::timeout_t hs_exit_timeout,
    output dsi_regs_pkg::timeout_t hs_go_timeout,
    output dsi_regs_pkg::timeout_t hs_trail_timeout
);
    import dsi_regs_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tlpx_timeout       <= RST_TLPX;
            hs_prepare_timeout <= RST_HS_PREPARE;
            hs_exit_timeout    <= RST_HS_EXIT;
            hs_go_timeout      <= RST_HS_GO;
            hs_trail_timeout   <= RST_HS_TRAIL;
        end else begin
            if (regs.wr_sel[REG_TR1]) begin
                tlpx_timeout       <= regs.wdata[TR1_TLPX_LSB +: TIMEOUT_W];
                hs_prepare_timeout <= regs.wdata[TR1_PREP_LSB +: TIMEOUT_W];
                hs_exit_timeout    <= regs.wdata[TR1_EXIT_LSB +: TIMEOUT_W];
            end
            if (regs.wr_sel[REG_TR2]) begin
                hs_go_timeout    <= regs.wdata[TR2_GO_LSB +: TIMEOUT_W];
                hs_trail_timeout <= regs.wdata[TR2_TRAIL_LSB +: TIMEOUT_W];
            end
        end
    end

    // unused bits read as zero.
    always_comb begin
        regs.tr1_word                             = '0;
        regs.tr1_word[TR1_TLPX_LSB +: TIMEOUT_W]  = tlpx_timeout;
        regs.tr1_word[TR1_PREP_LSB +: TIMEOUT_W]  = hs_prepare_timeout;
        regs.tr1_word[TR1_EXIT_LSB +: TIMEOUT_W]  = hs_exit_timeout;
        regs.tr2_word                             = '0;
        regs.tr2_word[TR2_GO_LSB +: TIMEOUT_W]    = hs_go_timeout;
        regs.tr2_word[TR2_TRAIL_LSB +: TIMEOUT_W] = hs_trail_timeout;
    end

endmodule

/* source/dsi_tx_regs.sv */
`timescale 1ns/1ps

module dsi_tx_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic                     irq,
    input  dsi_regs_pkg::addr_t      avl_mm_addr,
    input  logic                     avl_mm_read,
    output dsi_regs_pkg::word_t      avl_mm_readdata,
    output dsi_regs_pkg::resp_t      avl_mm_response,
    input  logic                     avl_mm_write,
    input  dsi_regs_pkg::word_t      avl_mm_writedata,
    output logic                     avl_mm_waitrequest,
    output logic                     packet_assembler_enable,
    output logic                     lanes_enable,
    output logic                     clk_out_enable,
    output logic                     send_cmd,
    output dsi_regs_pkg::lanes_num_t lanes_number,
    output dsi_regs_pkg::cmd_t       cmd_packet,
    output dsi_regs_pkg::timeout_t   tlpx_timeout,
    output dsi_regs_pkg::timeout_t   hs_prepare_timeout,
    output dsi_regs_pkg::timeout_t   hs_exit_timeout,
    output dsi_regs_pkg::timeout_t   hs_go_timeout,
    output dsi_regs_pkg::timeout_t   hs_trail_timeout,
    input  logic                     pix_buffer_underflow_set,
    input  logic                     lanes_ready_set,
    input  logic                     clk_ready_set,
    input  logic                     lanes_active
);

    dsi_reg_if u_regs_if ();   // decoded access shared by agent and banks.

    dsi_bus_agent u_agent (
        .clk             (clk),
        .rst_n           (rst_n),
        .avl_addr        (avl_mm_addr),
        .avl_read        (avl_mm_read),
        .avl_write       (avl_mm_write),
        .avl_writedata   (avl_mm_writedata),
        .avl_readdata    (avl_mm_readdata),
        .avl_response    (avl_mm_response),
        .avl_waitrequest (avl_mm_waitrequest),
        .regs            (u_regs_if.agent)
    );

    dsi_ctrl_regs u_ctrl (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .regs                    (u_regs_if.bank),
        .lanes_active            (lanes_active),
        .packet_assembler_enable (packet_assembler_enable),
        .lanes_enable            (lanes_enable),
        .clk_out_enable          (clk_out_enable),
        .send_cmd                (send_cmd),
        .lanes_number            (lanes_number),
        .cmd_packet              (cmd_packet)
    );

    dsi_irq_regs u_irq (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .regs                     (u_regs_if.bank),
        .pix_buffer_underflow_set (pix_buffer_underflow_set),
        .lanes_ready_set          (lanes_ready_set),
        .clk_ready_set            (clk_ready_set),
        .lanes_active             (lanes_active),
        .irq                      (irq)
    );

    dsi_timing_regs u_timing (
        .clk                (clk),
        .rst_n              (rst_n),
        .regs               (u_regs_if.bank),
        .tlpx_timeout       (tlpx_timeout),
        .hs_prepare_timeout (hs_prepare_timeout),
        .hs_exit_timeout    (hs_exit_timeout),
        .hs_go_timeout      (hs_go_timeout),
        .hs_trail_timeout   (hs_trail_timeout)
    );

endmodule

/* vlog.f */
source/dsi_regs_pkg.sv
source/dsi_reg_if.sv
source/dsi_bus_agent.sv
source/dsi_ctrl_regs.sv
source/dsi_irq_regs.sv
source/dsi_timing_regs.sv
source/dsi_tx_regs.sv
sim/tb_clk_gen.sv
sim/dsi_tx_regs_tb.sv
